//--- logic/dcache_pkg.sv
// Shared widths, enums and structs for the uncached data port; referenced by scoped names
`default_nettype none

package dcache_pkg;

    localparam int unsigned XLEN   = 64;
    localparam int unsigned STRB_W = XLEN / 8;
    localparam int unsigned OFFS_W = $clog2(STRB_W);  // Byte offset within a beat

    typedef logic [XLEN-1:0]   data_t;
    typedef logic [XLEN-1:0]   addr_t;
    typedef logic [STRB_W-1:0] strb_t;

    typedef enum logic [1:0] {
        SIZE_B,
        SIZE_H,
        SIZE_W,
        SIZE_D
    } size_e;

    typedef enum logic [1:0] {
        MEM_LOAD,
        MEM_STORE,
        MEM_AMO
    } mem_op_e;

    typedef enum logic [3:0] {
        AMO_SWAP,
        AMO_ADD,
        AMO_XOR,
        AMO_AND,
        AMO_OR,
        AMO_MIN,
        AMO_MAX,
        AMO_MINU,
        AMO_MAXU
    } amo_op_e;

    typedef enum logic {
        EXC_LOAD_MISALIGN,
        EXC_STORE_MISALIGN
    } exc_cause_e;

    typedef struct packed {
        addr_t   address;
        data_t   value;        // Store data or AMO operand
        mem_op_e op;
        size_e   size;
        logic    is_unsigned;  // Zero-extend loads
        amo_op_e amo;
    } cache_req_t;

    typedef struct packed {
        data_t value;
    } cache_resp_t;

    typedef struct packed {
        exc_cause_e cause;
        addr_t      tval;
    } cache_exc_t;

    typedef struct packed {
        data_t data;
        strb_t strb;
    } mem_w_t;

    // Offset bits that must be zero for a naturally aligned access
    function automatic logic [OFFS_W-1:0] size_mask(input size_e size);
        size_mask = OFFS_W'((1 << size) - 1);
    endfunction

endpackage

`default_nettype wire

//--- logic/amo_alu.sv
// AMO arithmetic; computes the value written back from the old memory value and the operand
`timescale 1ns/1ps
`default_nettype none

module amo_alu (
    input  dcache_pkg::amo_op_e op,
    input  dcache_pkg::data_t   old_value,
    input  dcache_pkg::data_t   operand,
    output dcache_pkg::data_t   result
);

    logic lt_signed;
    logic lt_unsigned;

    // Word forms arrive sign-extended, so 64-bit compares cover them
    assign lt_signed   = $signed(old_value) < $signed(operand);
    assign lt_unsigned = old_value < operand;

    always_comb begin
        unique case (op)
            dcache_pkg::AMO_SWAP: result = operand;
            dcache_pkg::AMO_ADD:  result = old_value + operand;
            dcache_pkg::AMO_XOR:  result = old_value ^ operand;
            dcache_pkg::AMO_AND:  result = old_value & operand;
            dcache_pkg::AMO_OR:   result = old_value | operand;
            dcache_pkg::AMO_MIN:  result = lt_signed ? old_value : operand;
            dcache_pkg::AMO_MAX:  result = lt_signed ? operand : old_value;
            dcache_pkg::AMO_MINU: result = lt_unsigned ? old_value : operand;
            dcache_pkg::AMO_MAXU: result = lt_unsigned ? operand : old_value;
            default:              result = operand;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/load_align.sv
// Load data aligner; picks the addressed field out of a full read beat and extends it
`timescale 1ns/1ps
`default_nettype none

module load_align (
    input  logic                          clk,
    input  dcache_pkg::data_t             beat,
    input  logic [dcache_pkg::OFFS_W-1:0] offset,
    input  dcache_pkg::size_e             size,
    input  logic                          is_unsigned,
    output dcache_pkg::data_t             value
);

    dcache_pkg::data_t shifted;

    // Move the addressed byte down to lane 0
    assign shifted = beat >> {offset, 3'b000};

    always_comb begin
        unique case (size)
            dcache_pkg::SIZE_B: begin
                if (is_unsigned) value = dcache_pkg::data_t'(shifted[7:0]);
                else value = dcache_pkg::data_t'($signed(shifted[7:0]));
            end
            dcache_pkg::SIZE_H: begin
                if (is_unsigned) value = dcache_pkg::data_t'(shifted[15:0]);
                else value = dcache_pkg::data_t'($signed(shifted[15:0]));
            end
            dcache_pkg::SIZE_W: begin
                if (is_unsigned) value = dcache_pkg::data_t'(shifted[31:0]);
                else value = dcache_pkg::data_t'($signed(shifted[31:0]));
            end
            default: value = beat;  // Doubleword
        endcase
    end

    // Controller only presents offsets of accepted, aligned requests
    a_offset_aligned: assert property (@(posedge clk)
        (offset & dcache_pkg::size_mask(size)) == '0)
        else $error("Load offset %0d not aligned to size %s", offset, size.name());

endmodule

`default_nettype wire

//--- logic/store_align.sv
// Store data aligner; places write data in its byte lanes and builds the matching strobe
`timescale 1ns/1ps
`default_nettype none

module store_align (
    input  dcache_pkg::data_t             src,
    input  logic [dcache_pkg::OFFS_W-1:0] offset,
    input  dcache_pkg::size_e             size,
    output dcache_pkg::mem_w_t            beat
);

    dcache_pkg::strb_t strb_base;

    always_comb begin
        unique case (size)
            dcache_pkg::SIZE_B: strb_base = dcache_pkg::strb_t'(8'h01);
            dcache_pkg::SIZE_H: strb_base = dcache_pkg::strb_t'(8'h03);
            dcache_pkg::SIZE_W: strb_base = dcache_pkg::strb_t'(8'h0f);
            default:            strb_base = '1;
        endcase
    end

    // Upper bytes of src fall off the top of the beat
    assign beat.data = src << {offset, 3'b000};
    assign beat.strb = strb_base << offset;

endmodule

`default_nettype wire

//--- logic/dcache_ctrl.sv
// Request FSM of the uncached port; sequences the AR/R and AW/W/B channels per request
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          req_valid,
    input  dcache_pkg::cache_req_t        req,
    output logic                          req_ready,
    output logic                          resp_valid,
    output dcache_pkg::cache_resp_t       resp,
    output logic                          ex_valid,
    output dcache_pkg::cache_exc_t        ex,
    output logic                          ar_valid,
    output dcache_pkg::addr_t             ar_addr,
    input  logic                          ar_ready,
    input  logic                          r_valid,
    output logic                          aw_valid,
    output dcache_pkg::addr_t             aw_addr,
    input  logic                          aw_ready,
    output logic                          w_valid,
    output dcache_pkg::mem_w_t            w,
    input  logic                          w_ready,
    input  logic                          b_valid,
    output logic [dcache_pkg::OFFS_W-1:0] load_offset,
    output dcache_pkg::size_e             load_size,
    output logic                          load_unsigned,
    input  dcache_pkg::data_t             load_value,
    output logic [dcache_pkg::OFFS_W-1:0] store_offset,
    output dcache_pkg::size_e             store_size,
    output dcache_pkg::data_t             store_src,
    input  dcache_pkg::mem_w_t            store_beat,
    output dcache_pkg::amo_op_e           amo_op,
    output dcache_pkg::data_t             amo_old,
    output dcache_pkg::data_t             amo_operand,
    input  dcache_pkg::data_t             amo_result
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_R,   // AR issued, waiting for the read beat
        AMO,      // Write-back value computed here
        WAIT_W    // AW and W issued, waiting for B
    } state_e;

    state_e                 state;
    dcache_pkg::cache_req_t req_q;
    logic                   accept;
    logic                   aligned;

    assign req_ready = state == IDLE;
    assign accept    = req_valid && req_ready;
    assign aligned   = (req.address[dcache_pkg::OFFS_W-1:0]
                        & dcache_pkg::size_mask(req.size)) == '0;

    assign ar_addr = req_q.address;
    assign aw_addr = req_q.address;

    assign load_offset   = req_q.address[dcache_pkg::OFFS_W-1:0];
    assign load_size     = req_q.size;
    assign load_unsigned = req_q.is_unsigned && req_q.op != dcache_pkg::MEM_AMO;

    // Stores are aligned straight from the request, AMOs from the ALU result
    assign store_offset = state == AMO ? req_q.address[dcache_pkg::OFFS_W-1:0]
                                       : req.address[dcache_pkg::OFFS_W-1:0];
    assign store_size   = state == AMO ? req_q.size : req.size;
    assign store_src    = state == AMO ? amo_result : req.value;

    assign amo_op      = req_q.amo;
    assign amo_old     = resp.value;
    assign amo_operand = req_q.size == dcache_pkg::SIZE_W
                       ? dcache_pkg::data_t'($signed(req_q.value[31:0])) : req_q.value;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state      <= IDLE;
            req_q      <= '0;
            resp_valid <= 1'b0;
            ex_valid   <= 1'b0;
            ar_valid   <= 1'b0;
            aw_valid   <= 1'b0;
            w_valid    <= 1'b0;
        end else begin
            resp_valid <= 1'b0;
            ex_valid   <= 1'b0;
            unique case (state)
                IDLE: begin
                    if (accept && !aligned) begin
                        ex_valid <= 1'b1;
                    end else if (accept) begin
                        req_q <= req;
                        if (req.op == dcache_pkg::MEM_STORE) begin
                            aw_valid <= 1'b1;
                            w_valid  <= 1'b1;
                            state    <= WAIT_W;
                        end else begin
                            ar_valid <= 1'b1;
                            state    <= WAIT_R;
                        end
                    end
                end
                WAIT_R: begin
                    if (ar_ready) ar_valid <= 1'b0;
                    if (r_valid) begin
                        if (req_q.op == dcache_pkg::MEM_AMO) begin
                            state <= AMO;
                        end else begin
                            resp_valid <= 1'b1;
                            state      <= IDLE;
                        end
                    end
                end
                AMO: begin
                    aw_valid <= 1'b1;
                    w_valid  <= 1'b1;
                    state    <= WAIT_W;
                end
                WAIT_W: begin
                    if (aw_ready) aw_valid <= 1'b0;
                    if (w_ready) w_valid <= 1'b0;
                    if (b_valid) begin
                        resp_valid <= 1'b1;  // AMO keeps the old value in resp
                        state      <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept && !aligned) begin
            ex.cause <= req.op == dcache_pkg::MEM_LOAD ? dcache_pkg::EXC_LOAD_MISALIGN
                                                       : dcache_pkg::EXC_STORE_MISALIGN;
            ex.tval  <= req.address;
        end
        if (accept || state == AMO) w <= store_beat;
        if (state == WAIT_R && r_valid) resp.value <= load_value;
    end

    a_write_path: assert property (@(posedge clk) disable iff (!rstn)
        (aw_valid || w_valid) |-> state == WAIT_W)
        else $error("AW/W valid high outside the write wait state");

    a_idle_quiet: assert property (@(posedge clk) disable iff (!rstn)
        req_ready |-> !(ar_valid || aw_valid || w_valid))
        else $error("Bus valid still high while ready for a new request");

    a_one_result: assert property (@(posedge clk) disable iff (!rstn)
        !(resp_valid && ex_valid))
        else $error("Response and exception signalled together");

endmodule

`default_nettype wire

//--- logic/dcache_uncached.sv
// Uncached data-memory port top level; connect the CPU request side and the memory channels
`timescale 1ns/1ps
`default_nettype none

module dcache_uncached (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    req_valid,
    input  dcache_pkg::cache_req_t  req,
    output logic                    req_ready,
    output logic                    resp_valid,
    output dcache_pkg::cache_resp_t resp,
    output logic                    ex_valid,
    output dcache_pkg::cache_exc_t  ex,
    output logic                    ar_valid,
    output dcache_pkg::addr_t       ar_addr,
    input  logic                    ar_ready,
    input  logic                    r_valid,
    input  dcache_pkg::data_t       r_data,
    output logic                    aw_valid,
    output dcache_pkg::addr_t       aw_addr,
    input  logic                    aw_ready,
    output logic                    w_valid,
    output dcache_pkg::mem_w_t      w,
    input  logic                    w_ready,
    input  logic                    b_valid
);

    logic [dcache_pkg::OFFS_W-1:0] load_offset;
    dcache_pkg::size_e             load_size;
    logic                          load_unsigned;
    dcache_pkg::data_t             load_value;

    logic [dcache_pkg::OFFS_W-1:0] store_offset;
    dcache_pkg::size_e             store_size;
    dcache_pkg::data_t             store_src;
    dcache_pkg::mem_w_t            store_beat;

    dcache_pkg::amo_op_e           amo_op;
    dcache_pkg::data_t             amo_old;
    dcache_pkg::data_t             amo_operand;
    dcache_pkg::data_t             amo_result;

    dcache_ctrl ctrl0 (.*);

    load_align load0 (
        .clk         (clk),
        .beat        (r_data),
        .offset      (load_offset),
        .size        (load_size),
        .is_unsigned (load_unsigned),
        .value       (load_value)
    );

    store_align store0 (
        .src    (store_src),
        .offset (store_offset),
        .size   (store_size),
        .beat   (store_beat)
    );

    amo_alu alu0 (
        .op        (amo_op),
        .old_value (amo_old),
        .operand   (amo_operand),
        .result    (amo_result)
    );

endmodule

`default_nettype wire

//--- test/mem_model.sv
// Testbench memory for the uncached port; answers the bus channels with random stall cycles
`timescale 1ns/1ps
`default_nettype none

module mem_model (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    ar_valid,
    input  dcache_pkg::addr_t       ar_addr,
    output logic                    ar_ready,
    output logic                    r_valid,
    output dcache_pkg::data_t       r_data,
    input  logic                    aw_valid,
    input  dcache_pkg::addr_t       aw_addr,
    output logic                    aw_ready,
    input  logic                    w_valid,
    input  dcache_pkg::mem_w_t      w,
    output logic                    w_ready,
    output logic                    b_valid
);

    dcache_pkg::data_t  mem [32];
    logic [31:0]        lfsr;
    logic [1:0]         ar_cnt, r_cnt, aw_cnt, w_cnt, b_cnt;
    logic               r_pend, aw_done, w_done;
    logic [4:0]         rd_idx, wr_idx;
    dcache_pkg::mem_w_t wr_beat;

    // Same fill rule as the testbench reference memory
    function automatic dcache_pkg::data_t word_pattern(int idx);
        logic [4:0] i;
        i = 5'(idx);
        return {8{3'b101, i}} ^ 64'h3c5a_96e1_0f87_d24b;
    endfunction

    // Galois LFSR, one step per bit taken
    function automatic logic [1:0] rand2();
        logic [1:0] r;
        for (int i = 0; i < 2; i++) begin
            r[i] = lfsr[0];
            lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
        end
        return r;
    endfunction

    initial begin
        for (int i = 0; i < 32; i++) mem[i] = word_pattern(i);
    end

    always @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            lfsr = 32'hab01_86ed;
            {ar_ready, r_valid, aw_ready, w_ready, b_valid} <= '0;
            {r_pend, aw_done, w_done} <= '0;
            {ar_cnt, r_cnt, aw_cnt, w_cnt, b_cnt} <= '0;
            r_data <= '0;
        end else begin
            r_valid <= 1'b0;
            b_valid <= 1'b0;
            if (ar_ready) begin
                ar_ready <= 1'b0;  // Handshake done this edge
                r_pend   <= 1'b1;
                r_cnt    <= rand2();
                ar_cnt   <= rand2();
            end else if (ar_valid && !r_pend) begin
                if (ar_cnt == 2'd0) begin
                    ar_ready <= 1'b1;
                    rd_idx   <= ar_addr[7:3];
                end else ar_cnt <= ar_cnt - 2'd1;
            end
            if (r_pend) begin
                if (r_cnt == 2'd0) begin
                    r_valid <= 1'b1;
                    r_data  <= mem[rd_idx];
                    r_pend  <= 1'b0;
                end else r_cnt <= r_cnt - 2'd1;
            end
            if (aw_ready) begin
                aw_ready <= 1'b0;
                aw_done  <= 1'b1;
                aw_cnt   <= rand2();
            end else if (aw_valid && !aw_done) begin
                if (aw_cnt == 2'd0) begin
                    aw_ready <= 1'b1;
                    wr_idx   <= aw_addr[7:3];
                end else aw_cnt <= aw_cnt - 2'd1;
            end
            if (w_ready) begin
                w_ready <= 1'b0;
                w_done  <= 1'b1;
                w_cnt   <= rand2();
            end else if (w_valid && !w_done) begin
                if (w_cnt == 2'd0) begin
                    w_ready <= 1'b1;
                    wr_beat <= w;
                end else w_cnt <= w_cnt - 2'd1;
            end
            if (aw_done && w_done) begin
                if (b_cnt == 2'd0) begin
                    for (int b = 0; b < 8; b++) begin
                        if (wr_beat.strb[b]) mem[wr_idx][b*8 +: 8] <= wr_beat.data[b*8 +: 8];
                    end
                    b_valid <= 1'b1;
                    aw_done <= 1'b0;
                    w_done  <= 1'b0;
                    b_cnt   <= rand2();
                end else b_cnt <= b_cnt - 2'd1;
            end
        end
    end

endmodule

`default_nettype wire

//--- test/dcache_uncached_tb.sv
// Testbench top for the uncached port; runs a table of loads, stores, AMOs and faults
`timescale 1ns/1ps
`default_nettype none

module dcache_uncached_tb;

    typedef struct {
        string                  name;
        dcache_pkg::mem_op_e    op;
        dcache_pkg::addr_t      addr;
        dcache_pkg::size_e      size;
        logic                   uns;
        dcache_pkg::amo_op_e    amo;
        dcache_pkg::data_t      value;
        logic                   expect_exc;
        dcache_pkg::exc_cause_e cause;
        logic                   check;      // Stores return no defined value
        dcache_pkg::data_t      expected;
    } test_t;

    logic clk, rstn, req_valid, req_ready, resp_valid, ex_valid;
    logic ar_valid, ar_ready, r_valid, aw_valid, aw_ready, w_valid, w_ready, b_valid;
    logic busy;
    dcache_pkg::cache_req_t  req;
    dcache_pkg::cache_resp_t resp;
    dcache_pkg::cache_exc_t  ex;
    dcache_pkg::addr_t       ar_addr, aw_addr;
    dcache_pkg::data_t       r_data;
    dcache_pkg::mem_w_t      w;
    dcache_pkg::data_t       shadow [32];
    test_t                   tests [$];

    dcache_uncached dut0 (.*);
    mem_model mem0 (.*);

    always #10 clk = ~clk;

    task automatic stop_run();
        $display("Something failed");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic report_error(string msg);
        $display("%s", msg);
        stop_run();
    endtask

    task automatic report_mismatch(string name, dcache_pkg::data_t exp, dcache_pkg::data_t act);
        $display("Mismatch %s: expected %h, actual %h", name, exp, act);
        stop_run();
    endtask

    function automatic dcache_pkg::data_t word_pattern(int idx);
        logic [4:0] i;
        i = 5'(idx);
        return {8{3'b101, i}} ^ 64'h3c5a_96e1_0f87_d24b;
    endfunction

    function automatic dcache_pkg::data_t extend_field(dcache_pkg::data_t word, int off, int sz,
                                                       logic uns);
        dcache_pkg::data_t mask, f;
        int nbits;
        nbits = 8 << sz;
        mask  = (sz == 3) ? '1 : ((64'd1 << nbits) - 64'd1);
        f     = (word >> (off * 8)) & mask;
        if (!uns && sz != 3 && f[nbits-1]) f = f | ~mask;
        return f;
    endfunction

    function automatic dcache_pkg::data_t merge_bytes(dcache_pkg::data_t word,
                                                      dcache_pkg::data_t data, int off, int sz);
        for (int b = 0; b < 8; b++) begin
            if (b >= off && b < off + (1 << sz)) word[b*8 +: 8] = data[(b-off)*8 +: 8];
        end
        return word;
    endfunction

    function automatic dcache_pkg::data_t amo_rule(dcache_pkg::amo_op_e op,
                                                   dcache_pkg::data_t a, dcache_pkg::data_t b);
        case (op)
            dcache_pkg::AMO_ADD:  return a + b;
            dcache_pkg::AMO_XOR:  return a ^ b;
            dcache_pkg::AMO_AND:  return a & b;
            dcache_pkg::AMO_OR:   return a | b;
            dcache_pkg::AMO_MIN:  return ($signed(a) < $signed(b)) ? a : b;
            dcache_pkg::AMO_MAX:  return ($signed(a) < $signed(b)) ? b : a;
            dcache_pkg::AMO_MINU: return (a < b) ? a : b;
            dcache_pkg::AMO_MAXU: return (a < b) ? b : a;
            default:              return b;
        endcase
    endfunction

    // Appends one entry and updates the reference memory
    task automatic add_test(string name, dcache_pkg::mem_op_e op, dcache_pkg::addr_t addr,
                            dcache_pkg::size_e size, logic uns, dcache_pkg::amo_op_e amo,
                            dcache_pkg::data_t value);
        test_t t;
        dcache_pkg::data_t word, opnd;
        int off, sz, idx;
        sz  = int'(size);
        off = int'(addr[2:0]);
        idx = int'(addr[7:3]);
        t = '{name, op, addr, size, uns, amo, value, 1'b0, dcache_pkg::EXC_LOAD_MISALIGN,
              1'b0, '0};
        word = shadow[idx];
        if ((off % (1 << sz)) != 0) begin
            t.expect_exc = 1'b1;
            if (op != dcache_pkg::MEM_LOAD) t.cause = dcache_pkg::EXC_STORE_MISALIGN;
        end else if (op == dcache_pkg::MEM_LOAD) begin
            t.check    = 1'b1;
            t.expected = extend_field(word, off, sz, uns);
        end else if (op == dcache_pkg::MEM_STORE) begin
            shadow[idx] = merge_bytes(word, value, off, sz);
        end else begin
            t.check    = 1'b1;
            t.expected = extend_field(word, off, sz, 1'b0);
            opnd = (sz == 2) ? extend_field(value, 0, 2, 1'b0) : value;
            shadow[idx] = merge_bytes(word, amo_rule(amo, t.expected, opnd), off, sz);
        end
        tests.push_back(t);
    endtask

    task automatic load_word(string name, dcache_pkg::addr_t addr);
        add_test(name, dcache_pkg::MEM_LOAD, addr, dcache_pkg::SIZE_D, 1'b0,
                 dcache_pkg::AMO_SWAP, '0);
    endtask

    task automatic build_tests();
        dcache_pkg::addr_t a;
        dcache_pkg::data_t v;
        for (int i = 0; i < 32; i++) shadow[i] = word_pattern(i);
        for (int sz = 0; sz < 4; sz++) begin
            for (int off = 0; off < 8; off += (1 << sz)) begin
                for (int u = 0; u < 2; u++) begin
                    add_test($sformatf("load_s%0d_o%0d_u%0d", sz, off, u), dcache_pkg::MEM_LOAD,
                             64'h28 + 64'(off), dcache_pkg::size_e'(2'(sz)), 1'(u),
                             dcache_pkg::AMO_SWAP, '0);
                end
            end
        end
        for (int sz = 0; sz < 4; sz++) begin
            a = 64'h40 + 64'(8 * sz)
              + ((sz == 0) ? 64'd3 : (sz == 1) ? 64'd6 : (sz == 2) ? 64'd4 : 64'd0);
            add_test($sformatf("store_s%0d", sz), dcache_pkg::MEM_STORE, a,
                     dcache_pkg::size_e'(2'(sz)), 1'b0, dcache_pkg::AMO_SWAP,
                     64'hfedc_ba98_7654_3210 ^ 64'(sz));
            load_word($sformatf("store_s%0d_check", sz), {a[63:3], 3'b000});
        end
        for (int op = 0; op < 9; op++) begin
            a = 64'h60 + 64'(8 * op);
            v = 64'h0123_4567_89ab_cdef ^ (64'(op) * 64'h1111_1111_1111_1111);
            // Operand sign opposite to the old value so signed and unsigned compares differ
            v[31] = ~shadow[a[7:3]][63];
            add_test($sformatf("amo_w_op%0d", op), dcache_pkg::MEM_AMO, a + 64'd4,
                     dcache_pkg::SIZE_W, 1'b0, dcache_pkg::amo_op_e'(4'(op)), v);
            load_word($sformatf("amo_w_op%0d_check", op), a);
            v = ~v;
            v[63] = ~shadow[a[7:3]][63];
            add_test($sformatf("amo_d_op%0d", op), dcache_pkg::MEM_AMO, a,
                     dcache_pkg::SIZE_D, 1'b0, dcache_pkg::amo_op_e'(4'(op)), v);
            load_word($sformatf("amo_d_op%0d_check", op), a);
        end
        add_test("misalign_load", dcache_pkg::MEM_LOAD, 64'hffff_0000_0000_0031,
                 dcache_pkg::SIZE_H, 1'b0, dcache_pkg::AMO_SWAP, '0);
        add_test("misalign_store", dcache_pkg::MEM_STORE, 64'h3a, dcache_pkg::SIZE_W, 1'b0,
                 dcache_pkg::AMO_SWAP, '1);
        add_test("misalign_amo", dcache_pkg::MEM_AMO, 64'h34, dcache_pkg::SIZE_D, 1'b0,
                 dcache_pkg::AMO_ADD, 64'd1);
        load_word("misalign_word6", 64'h30);
        load_word("misalign_word7", 64'h38);
    endtask

    // Results may only appear for a request in flight
    always @(negedge clk) begin
        if (rstn && !busy) begin
            assert (!(resp_valid || ex_valid))
            else report_error("A result appeared without any request");
        end
    end

    initial begin
        #1;
        repeat (40 * tests.size() + 20) @(posedge clk);
        $display("Watchdog expired before the table finished");
        $display("Something failed");
        $fatal(1, "Timeout");
    end

    initial begin
        clk = 1'b0;
        rstn = 1'b0;
        req_valid = 1'b0;
        req = '0;
        busy = 1'b0;
        build_tests();
        repeat (4) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        assert (req_ready && !resp_valid && !ex_valid && !ar_valid && !aw_valid && !w_valid)
        else report_error("Outputs not idle after reset");
        foreach (tests[i]) begin
            @(negedge clk);
            assert (req_ready) else report_error({"Port not ready before ", tests[i].name});
            @(posedge clk);
            busy <= 1'b1;
            req_valid <= 1'b1;
            req <= '{address: tests[i].addr, value: tests[i].value, op: tests[i].op,
                     size: tests[i].size, is_unsigned: tests[i].uns, amo: tests[i].amo};
            @(posedge clk);
            req_valid <= 1'b0;
            forever begin
                @(negedge clk);
                if (resp_valid || ex_valid) break;
                assert (!req_ready) else report_error({"Ready high in flight in ", tests[i].name});
            end
            if (tests[i].expect_exc) begin
                assert (ex_valid) else report_error({"No exception for ", tests[i].name});
                assert (ex.cause == tests[i].cause)
                else report_mismatch(tests[i].name, 64'(tests[i].cause), 64'(ex.cause));
                assert (ex.tval == tests[i].addr)
                else report_mismatch(tests[i].name, tests[i].addr, ex.tval);
            end else begin
                assert (resp_valid) else report_error({"Unexpected exception in ", tests[i].name});
                if (tests[i].check) begin
                    assert (resp.value == tests[i].expected)
                    else report_mismatch(tests[i].name, tests[i].expected, resp.value);
                end
            end
            @(posedge clk);
            busy <= 1'b0;
        end
        repeat (2) @(posedge clk);
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- dcache_uncached.f
logic/dcache_pkg.sv
logic/amo_alu.sv
logic/load_align.sv
logic/store_align.sv
logic/dcache_ctrl.sv
logic/dcache_uncached.sv
test/mem_model.sv
test/dcache_uncached_tb.sv

//--- Makefile
# Verilator build and run for the uncached data port testbench

VERILATOR ?= verilator
TOP       ?= dcache_uncached_tb
FILELIST  ?= dcache_uncached.f
BUILD_DIR ?= obj_dir
SIM       ?= sim
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove build output"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR SIM VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(SIM)
	./$(BUILD_DIR)/$(SIM)

clean:
	rm -rf $(BUILD_DIR)
